//--- spi_macros.svh
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// command word is op bit, register address and write data
`define SPI_CMD_WIDTH 12

`define SPI_READ_WIDTH 8

`define SPI_ADDR_BITS 3

// clk cycles per sclk half period
`define SPI_SCLK_HALF 4

// clk cycles with cs_n high between read address and read data
`define SPI_READ_GAP 100

`endif

//--- spi_pkg.sv
`default_nettype none

package spi_pkg;

  // bit 11 of the command word
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  typedef enum logic [2:0] {
    IDLE   = 3'd0, // waiting for an op with cs_n high
    W_DATA = 3'd1, // all command bits out on mosi
    R_ADDR = 3'd2, // op and address bits out
    R_GAP  = 3'd3, // cs_n high between read phases
    R_DATA = 3'd4, // read byte in from miso
    R_HOLD = 3'd5, // byte waits for the read stage
    FINISH = 3'd6  // one cycle cs_n high after a write
  } spi_state_e;

endpackage

`default_nettype wire

//--- spi_cmd_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_cmd_stage
  import spi_pkg::*;
(
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          cmd_valid,
  input  wire  [`SPI_CMD_WIDTH-1:0]    cmd_data,
  output logic                         cmd_ready,
  output logic                         op_valid,
  output spi_op_e                      op,
  output logic [`SPI_ADDR_BITS-1:0]    op_addr,
  output logic [`SPI_READ_WIDTH-1:0]   op_wdata,
  input  wire                          op_ready
);

  logic full;
  logic load;

  // free now, or freed by the engine on this edge
  assign cmd_ready = !full || op_ready;
  assign load      = cmd_valid && cmd_ready;
  assign op_valid  = full;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full <= 1'b0;
    end
    else if (load)
    begin
      full <= 1'b1;
    end
    else if (op_ready)
    begin
      full <= 1'b0; // engine took the op
    end
  end

  // split the command word into its fields
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      op       <= spi_op_e'(cmd_data[`SPI_CMD_WIDTH-1]);
      op_addr  <= cmd_data[`SPI_CMD_WIDTH-2 -: `SPI_ADDR_BITS];
      op_wdata <= cmd_data[`SPI_READ_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

//--- spi_frame_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_frame_engine
  import spi_pkg::*;
(
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          op_valid,
  input  wire  spi_op_e                op,
  input  wire  [`SPI_ADDR_BITS-1:0]    op_addr,
  input  wire  [`SPI_READ_WIDTH-1:0]   op_wdata,
  output logic                         op_ready,
  output logic                         rd_in_valid,
  output logic [`SPI_READ_WIDTH-1:0]   rd_in_data,
  input  wire                          rd_in_ready,
  output logic                         sclk,
  output logic                         cs_n,
  output logic                         mosi,
  input  wire                          miso
);

  localparam int HALF_W     = $clog2(`SPI_SCLK_HALF + 1);
  localparam int BIT_W      = $clog2(`SPI_CMD_WIDTH + 1);
  localparam int GAP_W      = $clog2(`SPI_READ_GAP + 1);
  localparam int ADDR_PHASE = `SPI_ADDR_BITS + 1; // op bit plus address

  spi_state_e state;
  spi_state_e state_nxt;

  logic [HALF_W-1:0]          half_cnt;
  logic [BIT_W-1:0]           bit_cnt;
  logic [GAP_W-1:0]           gap_cnt;
  logic [`SPI_CMD_WIDTH-1:0]  tx_sr;
  logic [`SPI_READ_WIDTH-1:0] rx_sr;

  logic start;
  logic shifting;
  logic half_tick;
  logic sclk_rise;
  logic bit_end;
  logic last_bit;
  logic gap_done;

  assign op_ready    = (state == IDLE);
  assign rd_in_valid = (state == R_HOLD);
  assign rd_in_data  = rx_sr;

  assign start     = op_valid && op_ready;
  assign shifting  = (state == W_DATA) || (state == R_ADDR) || (state == R_DATA);
  assign half_tick = shifting && (half_cnt == HALF_W'(`SPI_SCLK_HALF - 1));
  assign sclk_rise = half_tick && !sclk;
  assign bit_end   = half_tick && sclk; // sclk falls here
  assign gap_done  = (state == R_GAP) && (gap_cnt == GAP_W'(`SPI_READ_GAP - 1));

  // frame length depends on the phase
  always_comb
  begin
    case (state)
      W_DATA:  last_bit = (bit_cnt == BIT_W'(`SPI_CMD_WIDTH - 1));
      R_ADDR:  last_bit = (bit_cnt == BIT_W'(ADDR_PHASE - 1));
      R_DATA:  last_bit = (bit_cnt == BIT_W'(`SPI_READ_WIDTH - 1));
      default: last_bit = 1'b0;
    endcase
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        if (start)
          state_nxt = (op == OP_WRITE) ? W_DATA : R_ADDR;
      W_DATA:
        if (bit_end && last_bit)
          state_nxt = FINISH;
      R_ADDR:
        if (bit_end && last_bit)
          state_nxt = R_GAP;
      R_GAP:
        if (gap_done)
          state_nxt = R_DATA;
      R_DATA:
        if (bit_end && last_bit)
          state_nxt = R_HOLD;
      R_HOLD:
        if (rd_in_ready)
          state_nxt = IDLE;
      FINISH:
        state_nxt = IDLE;
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      bit_cnt  <= '0;
      gap_cnt  <= '0;
    end
    else
    begin
      if (!shifting || half_tick)
        half_cnt <= '0;
      else
        half_cnt <= half_cnt + 1'b1;

      if (start || gap_done)
        bit_cnt <= '0; // new phase
      else if (bit_end)
        bit_cnt <= bit_cnt + 1'b1;

      if (state == R_GAP)
        gap_cnt <= gap_cnt + 1'b1;
      else
        gap_cnt <= '0;
    end
  end

  // spi pins
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk <= 1'b0;
      cs_n <= 1'b1;
      mosi <= 1'b0;
    end
    else
    begin
      if (half_tick)
        sclk <= ~sclk;
      else if (!shifting)
        sclk <= 1'b0;

      if (start || gap_done)
        cs_n <= 1'b0;
      else if (bit_end && last_bit)
        cs_n <= 1'b1;

      if (start)
        mosi <= (op == OP_WRITE); // msb goes out with cs_n
      else if (bit_end && last_bit)
        mosi <= 1'b0;
      else if (bit_end && state != R_DATA)
        mosi <= tx_sr[`SPI_CMD_WIDTH-2];
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
      tx_sr <= {op, op_addr, op_wdata};
    else if (bit_end)
      tx_sr <= {tx_sr[`SPI_CMD_WIDTH-2:0], 1'b0};

    if (state == R_DATA && sclk_rise)
      rx_sr <= {rx_sr[`SPI_READ_WIDTH-2:0], miso}; // msb first
  end

endmodule

`default_nettype wire

//--- spi_read_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_read_stage (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          rd_in_valid,
  input  wire  [`SPI_READ_WIDTH-1:0]   rd_in_data,
  output logic                         rd_in_ready,
  output logic                         rd_valid,
  output logic [`SPI_READ_WIDTH-1:0]   rd_data,
  input  wire                          rd_ready
);

  logic full;
  logic load;

  assign rd_in_ready = !full || rd_ready; // host may drain on this edge
  assign load        = rd_in_valid && rd_in_ready;
  assign rd_valid    = full;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full <= 1'b0;
    end
    else if (load)
    begin
      full <= 1'b1;
    end
    else if (rd_ready)
    begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
      rd_data <= rd_in_data; // held until the host takes it
  end

endmodule

`default_nettype wire

//--- spi_master_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_master_top
  import spi_pkg::*;
(
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          cmd_valid,
  input  wire  [`SPI_CMD_WIDTH-1:0]    cmd_data,
  output logic                         cmd_ready,
  output logic                         rd_valid,
  output logic [`SPI_READ_WIDTH-1:0]   rd_data,
  input  wire                          rd_ready,
  output logic                         sclk,
  output logic                         cs_n,
  output logic                         mosi,
  input  wire                          miso
);

  // command stage to frame engine
  logic                        op_valid;
  spi_op_e                     op;
  logic [`SPI_ADDR_BITS-1:0]   op_addr;
  logic [`SPI_READ_WIDTH-1:0]  op_wdata;
  logic                        op_ready;

  // frame engine to read stage
  logic                        rd_in_valid;
  logic [`SPI_READ_WIDTH-1:0]  rd_in_data;
  logic                        rd_in_ready;

  spi_cmd_stage cmd_stage0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_data  (cmd_data),
    .cmd_ready (cmd_ready),
    .op_valid  (op_valid),
    .op        (op),
    .op_addr   (op_addr),
    .op_wdata  (op_wdata),
    .op_ready  (op_ready)
  );

  spi_frame_engine frame_engine0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_valid    (op_valid),
    .op          (op),
    .op_addr     (op_addr),
    .op_wdata    (op_wdata),
    .op_ready    (op_ready),
    .rd_in_valid (rd_in_valid),
    .rd_in_data  (rd_in_data),
    .rd_in_ready (rd_in_ready),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso)
  );

  spi_read_stage read_stage0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_in_valid (rd_in_valid),
    .rd_in_data  (rd_in_data),
    .rd_in_ready (rd_in_ready),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .rd_ready    (rd_ready)
  );

endmodule

`default_nettype wire

//--- tb_spi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module tb_spi_slave_model (
  input  wire   clk,
  input  wire   sclk,
  input  wire   cs_n,
  input  wire   mosi,
  output logic  miso,
  output int    cmd_frames,
  output int    err_cnt
);

  logic [7:0]  regs [8];
  logic [11:0] rx;
  logic [7:0]  tx;
  logic [2:0]  rd_addr;
  logic        rd_pending;
  logic        rd_data_phase;
  logic        frame_open;
  int          bit_cnt;
  int          gap_clks;

  initial
  begin
    for (int i = 0; i < 8; i++)
      regs[i] = 8'ha0 + 8'(i); // reset pattern a0 plus address
    miso          = 1'b0;
    cmd_frames    = 0;
    err_cnt       = 0;
    rd_pending    = 1'b0;
    rd_data_phase = 1'b0;
    frame_open    = 1'b0;
    bit_cnt       = 0;
    gap_clks      = 0;
  end

  // clocks with cs_n high as seen before this edge's update
  always @(posedge clk)
  begin
    if (cs_n)
      gap_clks = gap_clks + 1;
    else
      gap_clks = 0;
  end

  always @(negedge clk)
  begin
    assert (!(cs_n === 1'b1 && sclk === 1'b1)) else
    begin
      err_cnt++;
      $display("ERROR %0t: sclk high while cs_n is high", $time);
    end
  end

  always @(negedge cs_n)
  begin
    frame_open = 1'b1;
    bit_cnt    = 0;
    rx         = '0;
    if (rd_pending)
    begin
      assert (gap_clks >= `SPI_READ_GAP) else
      begin
        err_cnt++;
        $display("ERROR %0t: read gap %0d clocks too short", $time, gap_clks);
      end
      rd_data_phase = 1'b1;
      rd_pending    = 1'b0;
      tx            = regs[rd_addr];
      miso          = tx[7]; // msb ready before the first rising edge
      tx            = tx << 1;
    end
    else
      rd_data_phase = 1'b0;
  end

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      rx = {rx[10:0], mosi};
      bit_cnt++;
    end
  end

  always @(negedge sclk)
  begin
    if (!cs_n && rd_data_phase)
    begin
      miso = tx[7];
      tx   = tx << 1;
    end
  end

  always @(posedge cs_n)
  begin
    if (frame_open)
    begin
      frame_open = 1'b0;
      case (bit_cnt)
        12:
        begin
          assert (rx[11] == 1'b1 && !rd_pending && !rd_data_phase) else
          begin
            err_cnt++;
            $display("ERROR %0t: bad write frame %03h", $time, rx);
          end
          regs[rx[10:8]] = rx[7:0];
          cmd_frames++;
        end
        4:
        begin
          assert (rx[3] == 1'b0 && !rd_data_phase) else
          begin
            err_cnt++;
            $display("ERROR %0t: bad read address frame %01h", $time, rx[3:0]);
          end
          rd_pending = 1'b1;
          rd_addr    = rx[2:0];
        end
        8:
        begin
          assert (rd_data_phase) else
          begin
            err_cnt++;
            $display("ERROR %0t: data frame without read address", $time);
          end
          rd_data_phase = 1'b0;
          cmd_frames++;
        end
        default:
        begin
          err_cnt++;
          $display("ERROR %0t: frame with %0d bits", $time, bit_cnt);
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- tb_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module tb_spi_master;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  logic [11:0] cmd_data;
  logic        cmd_ready;
  logic        rd_valid;
  logic [7:0]  rd_data;
  logic        rd_ready;
  wire         sclk;
  wire         cs_n;
  wire         mosi;
  wire         miso;
  int          slave_frames;
  int          slave_errs;

  logic [11:0] cmds [$];
  logic [7:0]  exp_q [$];
  int          n_reads;
  int          errors;
  int          accepted;
  int          results;
  int          ready_cycle;
  bit          saw_full;
  bit          timed_out;
  logic [15:0] gap_lfsr;
  logic [15:0] rdy_lfsr;

  spi_master_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_data  (cmd_data),
    .cmd_ready (cmd_ready),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .rd_ready  (rd_ready),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

  tb_spi_slave_model slave0 (
    .clk        (clk),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso),
    .cmd_frames (slave_frames),
    .err_cnt    (slave_errs)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb)
      s = s ^ 16'hb400;
    return s;
  endfunction

  task automatic read_stimulus();
    int    fd;
    int    n;
    string line;
    logic [3:0] op;
    logic [3:0] addr;
    logic [7:0] wdata;
    logic [7:0] expd;
    fd = $fopen("spi_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("could not open spi_stimulus.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() > 1 && line.substr(0, 0) != "#")
      begin
        n = $sscanf(line, "%h %h %h %h", op, addr, wdata, expd);
        if (n == 4)
        begin
          cmds.push_back({op[0], addr[2:0], wdata});
          if (op[0] == 1'b0)
          begin
            exp_q.push_back(expd);
            n_reads++;
          end
        end
      end
    end
    $fclose(fd);
  endtask

  // result port and handshake monitor sampled mid-cycle
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (cmd_valid && cmd_ready)
        accepted++;
      if (cmd_valid && !cmd_ready)
        saw_full = 1'b1; // pipeline full
      if (rd_valid && rd_ready)
      begin
        results++;
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("a read result came out with no read left in the file");
        end
        else
        begin
          assert (rd_data == exp_q[0]) else
          begin
            errors++;
            $display("ERROR %0t: rd_data %02h expected %02h", $time, rd_data, exp_q[0]);
          end
          void'(exp_q.pop_front());
        end
      end
    end
  end

  // rd_ready held for 64-cycle stretches and high one time in four
  always
  begin
    @(posedge clk);
    #1;
    if (ready_cycle % 64 == 0)
    begin
      rd_ready = (rdy_lfsr[0] == 1'b0);
      rdy_lfsr = lfsr_step(rdy_lfsr);
      rd_ready = rd_ready && (rdy_lfsr[0] == 1'b0);
      rdy_lfsr = lfsr_step(rdy_lfsr);
    end
    ready_cycle++;
  end

  task automatic send_cmd(input logic [11:0] word);
    int  cnt;
    int  idle;
    bit  ok;
    idle = 0;
    for (int b = 0; b < 2; b++)
    begin
      idle     = (idle << 1) | gap_lfsr[0];
      gap_lfsr = lfsr_step(gap_lfsr);
    end
    repeat (idle)
    begin
      @(posedge clk);
      #1;
    end
    cmd_valid = 1'b1;
    cmd_data  = word;
    ok        = 1'b0;
    cnt       = 0;
    while (!ok && cnt < 5000)
    begin
      @(negedge clk);
      ok = cmd_ready;
      @(posedge clk);
      cnt++;
    end
    #1;
    cmd_valid = 1'b0;
    if (!ok)
    begin
      timed_out = 1'b1;
      $display("timed out waiting for cmd_ready on command %03h", word);
    end
  endtask

  task automatic end_run();
    $display("errors: testbench %0d, slave model %0d, timeout %0d",
             errors, slave_errs, timed_out);
    if (errors == 0 && slave_errs == 0 && !timed_out)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  endtask

  initial
  begin
    int cnt;
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd_data    = '0;
    rd_ready    = 1'b0;
    errors      = 0;
    accepted    = 0;
    results     = 0;
    n_reads     = 0;
    ready_cycle = 0;
    saw_full    = 1'b0;
    timed_out   = 1'b0;
    gap_lfsr    = 16'd58;
    rdy_lfsr    = 16'd58;
    read_stimulus();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (cmd_ready && !rd_valid && cs_n && !sclk && !mosi) else
    begin
      errors++;
      $display("ERROR %0t: outputs wrong after reset", $time);
    end
    @(posedge clk);
    #1;
    foreach (cmds[i])
    begin
      if (!timed_out)
        send_cmd(cmds[i]);
    end
    cnt = 0;
    while (!timed_out && cnt < 200000 &&
           !(results == n_reads && slave_frames == accepted && cs_n))
    begin
      @(posedge clk);
      cnt++;
    end
    if (!timed_out && cnt >= 200000)
    begin
      timed_out = 1'b1;
      $display("timed out waiting for the last results and frames");
    end
    assert (slave_frames == accepted && accepted == cmds.size()) else
    begin
      errors++;
      $display("ERROR %0t: %0d frames for %0d accepted commands", $time,
               slave_frames, accepted);
    end
    assert (results == n_reads && exp_q.size() == 0) else
    begin
      errors++;
      $display("ERROR %0t: %0d results for %0d reads", $time, results, n_reads);
    end
    assert (saw_full) else
    begin
      errors++;
      $display("ERROR %0t: cmd_ready never dropped", $time);
    end
    end_run();
  end

endmodule

`default_nettype wire

//--- spi_stimulus.txt
# op addr wdata expected, all hex; op 1 is a write, 0 a read
# expected is the read byte and is ignored for writes
1 0 3c 00
1 5 c7 00
0 0 00 3c
0 5 00 c7
0 2 00 a2
1 2 5a 00
0 2 00 5a
0 7 00 a7
0 7 00 a7
1 7 e1 00
1 7 1e 00
0 7 00 1e
0 3 00 a3
0 1 00 a1
1 1 99 00
0 1 00 99
0 4 00 a4
1 6 ff 00
0 6 00 ff
0 0 00 3c
0 6 00 ff
0 5 00 c7

//--- build.f
+incdir+.
spi_pkg.sv
spi_cmd_stage.sv
spi_frame_engine.sv
spi_read_stage.sv
spi_master_top.sv
tb_spi_slave_model.sv
tb_spi_master.sv

//--- Makefile
SIM    ?= verilator
TOP    ?= tb_spi_master
VFLAGS ?= --binary --timing -Wno-fatal
OBJDIR ?= obj_dir

SRCS := $(filter %.sv,$(shell cat build.f)) spi_macros.svh
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): build.f $(SRCS)
	$(SIM) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f build.f

# pass only if the testbench printed its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJDIR)
